//--- design/led_panel_pkg.sv
`default_nettype none

package led_panel_pkg;

  ////////////////////
  // Driver word format
  ////////////////////

  // Fixed by the driver chip shift register
  localparam int WORD_BITS = 16;

  typedef logic [WORD_BITS-1:0] pixel_t;
  typedef logic [7:0]           color_t;
  typedef logic [1:0]           color_idx_t;

  // Intensity codes selected by the colour button
  localparam color_t [3:0] COLOR_TABLE = {8'hFF, 8'hAA, 8'h55, 8'h00};

  ////////////////////
  // Controller
  ////////////////////

  typedef enum logic [2:0] {
    IDLE,
    CONF_SHIFT,
    CONF_LATCH,
    WAIT_LINE,
    LINE_SHIFT,
    LINE_LATCH
  } ctrl_state_t;

  // A wide lat marks a configuration write, a data latch is one cycle
  localparam int CONF_LATCH_CYCLES = 3;

  typedef struct packed {
    logic load_conf;
    logic start;
    logic sclk_phase;
  } shift_cmd_t;

endpackage

`default_nettype wire

//--- design/frame_source.sv
`default_nettype none

module frame_source
  import led_panel_pkg::*;
#(
  parameter int NUM_LANES       = 4,
  parameter int LINES           = 4,
  parameter int BLANKING_CYCLES = 72
) (
  input  wire  clock_33,
  input  wire  nrst,
  input  logic color_button,
  output logic sync,
  output logic pix_data,
  output logic line_ready
);

  localparam int BLANK_W = $clog2(BLANKING_CYCLES + 1);
  localparam int BIT_W   = $clog2(WORD_BITS);
  localparam int LANE_W  = $clog2(NUM_LANES);
  localparam int LINE_W  = $clog2(LINES + 1);

  logic [BLANK_W-1:0] blank_cnt;
  logic [BIT_W-1:0]   bit_pos;
  logic [LANE_W-1:0]  lane_cnt;
  logic [LINE_W-1:0]  line_cnt;
  logic [7:0]         word_idx;
  logic               active;
  logic               button_q;
  color_idx_t         color_idx;
  color_idx_t         color_cur;
  pixel_t             shreg;

  assign pix_data   = active & shreg[WORD_BITS-1];
  assign line_ready = active & (bit_pos == BIT_W'(WORD_BITS - 1)) &
                      (lane_cnt == LANE_W'(NUM_LANES - 1));

  // Button edge advances the pending colour
  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      button_q  <= 1'b0;
      color_idx <= '0;
    end else begin
      button_q <= color_button;
      if (color_button && !button_q)
        color_idx <= color_idx + 2'd1;
    end
  end

  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      blank_cnt <= '0;
      sync      <= 1'b0;
      active    <= 1'b0;
      color_cur <= '0;
    end else begin
      sync <= 1'b0;
      if (!active && !sync) begin
        if (blank_cnt == BLANK_W'(BLANKING_CYCLES - 1)) begin
          blank_cnt <= '0;
          sync      <= 1'b1;
        end else begin
          blank_cnt <= blank_cnt + 1'b1;
        end
      end
      if (sync) begin
        active    <= 1'b1;
        color_cur <= color_idx;
      end else if (line_ready && line_cnt == LINE_W'(LINES - 1)) begin
        active <= 1'b0;
      end
    end
  end

  // Word sequencing, counters restart at every sync
  always_ff @(posedge clock_33) begin
    if (sync) begin
      shreg    <= {COLOR_TABLE[color_idx], 8'h00};
      bit_pos  <= '0;
      lane_cnt <= '0;
      line_cnt <= '0;
      word_idx <= '0;
    end else if (active) begin
      if (bit_pos == BIT_W'(WORD_BITS - 1)) begin
        bit_pos  <= '0;
        word_idx <= word_idx + 8'd1;
        shreg    <= {COLOR_TABLE[color_cur], word_idx + 8'd1};
        if (line_ready) begin
          lane_cnt <= '0;
          line_cnt <= line_cnt + 1'b1;
        end else begin
          lane_cnt <= lane_cnt + 1'b1;
        end
      end else begin
        bit_pos <= bit_pos + 1'b1;
        shreg   <= {shreg[WORD_BITS-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

//--- design/lane_shifter.sv
`default_nettype none

module lane_shifter
  import led_panel_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  wire                   clock_33,
  input  wire                   nrst,
  input  logic                  pix_data,
  input  logic                  line_ready,
  input  pixel_t                conf,
  input  shift_cmd_t            cmd,
  output logic [NUM_LANES-1:0]  sin,
  output logic                  sclk,
  output logic                  line_held,
  output logic                  shift_done
);

  localparam int LINE_BITS = NUM_LANES * WORD_BITS;
  localparam int CNT_W     = $clog2(WORD_BITS);

  logic [LINE_BITS-2:0]    cap_chain;
  logic [LINE_BITS-1:0]    line_word;
  pixel_t [NUM_LANES-1:0]  shift_buf;
  logic [CNT_W-1:0]        bit_cnt;
  logic                    busy;
  logic                    capture;

  // Current bit completes the line held in the chain
  assign line_word = {cap_chain, pix_data};
  assign capture   = line_ready & ~busy;

  assign sclk       = busy & cmd.sclk_phase;
  assign shift_done = sclk & (bit_cnt == CNT_W'(WORD_BITS - 1));

  always_comb begin
    for (int n = 0; n < NUM_LANES; n++)
      sin[n] = busy & shift_buf[n][WORD_BITS-1];
  end

  always_ff @(posedge clock_33) begin
    cap_chain <= line_word[LINE_BITS-2:0];
  end

  ////////////////////
  // Shift buffer
  ////////////////////

  always_ff @(posedge clock_33) begin
    for (int n = 0; n < NUM_LANES; n++) begin
      if (cmd.load_conf)
        shift_buf[n] <= conf;
      else if (capture)
        shift_buf[n] <= line_word[(NUM_LANES-1-n)*WORD_BITS +: WORD_BITS];
      else if (sclk)
        shift_buf[n] <= {shift_buf[n][WORD_BITS-2:0], 1'b0};
    end
  end

  // Lane 0 arrives first, so it sits at the top of line_word
  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      busy      <= 1'b0;
      line_held <= 1'b0;
      bit_cnt   <= '0;
    end else begin
      if (cmd.load_conf || cmd.start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end else if (shift_done) begin
        busy <= 1'b0;
      end else if (sclk) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (cmd.load_conf || cmd.start)
        line_held <= 1'b0;
      else if (capture)
        line_held <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/gclk_gen.sv
`default_nettype none

module gclk_gen #(
  parameter int GCLK_PULSES = 16
) (
  input  wire  clock_33,
  input  wire  nrst,
  input  logic burst_start,
  output logic gclk
);

  localparam int CNT_W = $clog2(GCLK_PULSES + 1);

  // Pulses still owed after the current one
  logic [CNT_W-1:0] remaining;

  ////////////////////
  // Burst sequencing
  ////////////////////

  // gclk itself is the phase bit, one high then one low per pulse
  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      gclk      <= 1'b0;
      remaining <= '0;
    end else if (burst_start) begin
      // A new latch restarts the burst
      gclk      <= 1'b1;
      remaining <= CNT_W'(GCLK_PULSES - 1);
    end else if (gclk) begin
      gclk <= 1'b0;
    end else if (remaining != '0) begin
      gclk      <= 1'b1;
      remaining <= remaining - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/driver_ctrl.sv
`default_nettype none

module driver_ctrl
  import led_panel_pkg::*;
(
  input  wire        clock_33,
  input  wire        nrst,
  input  logic       line_held,
  input  logic       shift_done,
  output shift_cmd_t cmd,
  output logic       lat,
  output logic       burst_start
);

  localparam int LAT_W = $clog2(CONF_LATCH_CYCLES);

  ctrl_state_t       state;
  ctrl_state_t       state_next;
  logic [LAT_W-1:0]  lat_cnt;
  logic              phase;
  logic              in_shift;

  assign in_shift = (state == CONF_SHIFT) || (state == LINE_SHIFT);

  ////////////////////
  // Outputs
  ////////////////////

  assign lat         = (state == CONF_LATCH) || (state == LINE_LATCH);
  assign burst_start = (state == LINE_LATCH);

  always_comb begin
    cmd            = '0;
    cmd.load_conf  = (state == IDLE);
    cmd.start      = (state == WAIT_LINE) && line_held;
    cmd.sclk_phase = phase;
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_next = state;
    case (state)
      IDLE:
        state_next = CONF_SHIFT;
      CONF_SHIFT:
        if (shift_done)
          state_next = CONF_LATCH;
      CONF_LATCH:
        if (lat_cnt == LAT_W'(CONF_LATCH_CYCLES - 1))
          state_next = WAIT_LINE;
      WAIT_LINE:
        if (line_held)
          state_next = LINE_SHIFT;
      LINE_SHIFT:
        if (shift_done)
          state_next = LINE_LATCH;
      LINE_LATCH:
        // Single cycle data latch, burst starts here
        state_next = WAIT_LINE;
      default:
        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Half-bit phase, low on the first cycle of each bit
  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      phase <= 1'b0;
    end else begin
      phase <= in_shift & ~phase;
    end
  end

  // Counts the cycles of the configuration latch
  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      lat_cnt <= '0;
    end else if (state == CONF_LATCH) begin
      lat_cnt <= lat_cnt + 1'b1;
    end else begin
      lat_cnt <= '0;
    end
  end

endmodule

`default_nettype wire

//--- design/led_panel_top.sv
`default_nettype none

module led_panel_top
  import led_panel_pkg::*;
#(
  parameter int NUM_LANES       = 4,
  parameter int LINES           = 4,
  parameter int BLANKING_CYCLES = 72,
  parameter int GCLK_PULSES     = 16
) (
  input  wire                   clock_33,
  input  wire                   nrst,
  input  logic                  color_button,
  input  pixel_t                conf,
  output logic [NUM_LANES-1:0]  sin,
  output logic                  sclk,
  output logic                  lat,
  output logic                  gclk
);

  logic       pix_data;
  logic       line_ready;
  logic       line_held;
  logic       shift_done;
  logic       burst_start;
  shift_cmd_t cmd;

  ////////////////////
  // Pixel source
  ////////////////////

  // Line framing comes from line_ready, sync only paces the source
  frame_source #(
    .NUM_LANES       (NUM_LANES),
    .LINES           (LINES),
    .BLANKING_CYCLES (BLANKING_CYCLES)
  ) i_frame_source (
    .clock_33     (clock_33),
    .nrst         (nrst),
    .color_button (color_button),
    .sync         (),
    .pix_data     (pix_data),
    .line_ready   (line_ready)
  );

  ////////////////////
  // Driver chain
  ////////////////////

  driver_ctrl i_driver_ctrl (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .line_held   (line_held),
    .shift_done  (shift_done),
    .cmd         (cmd),
    .lat         (lat),
    .burst_start (burst_start)
  );

  lane_shifter #(
    .NUM_LANES (NUM_LANES)
  ) i_lane_shifter (
    .clock_33   (clock_33),
    .nrst       (nrst),
    .pix_data   (pix_data),
    .line_ready (line_ready),
    .conf       (conf),
    .cmd        (cmd),
    .sin        (sin),
    .sclk       (sclk),
    .line_held  (line_held),
    .shift_done (shift_done)
  );

  gclk_gen #(
    .GCLK_PULSES (GCLK_PULSES)
  ) i_gclk_gen (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .burst_start (burst_start),
    .gclk        (gclk)
  );

endmodule

`default_nettype wire

//--- sim/led_panel_chk.sv
`default_nettype none

module led_panel_chk #(
  parameter int NUM_LANES = 4
) (
  input wire                 clock_33,
  input wire                 nrst,
  input wire [NUM_LANES-1:0] sin,
  input wire                 sclk,
  input wire                 lat,
  input wire                 gclk
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // Driver protocol
  ////////////////////

  lat_sclk_apart: assert property (@(posedge clock_33) disable iff (!nrst)
    lat |-> !sclk)
    else $error("lat and sclk high in the same cycle");

  // Data is sampled by the driver on the sclk high phase
  sin_held: assert property (@(posedge clock_33) disable iff (!nrst)
    sclk |-> $stable(sin))
    else $error("sin changed while sclk was high");

  gclk_quiet_in_lat: assert property (@(posedge clock_33) disable iff (!nrst)
    lat |-> !gclk)
    else $error("gclk high during a latch");

endmodule

bind led_panel_top led_panel_chk #(
  .NUM_LANES (NUM_LANES)
) i_led_panel_chk (
  .clock_33 (clock_33),
  .nrst     (nrst),
  .sin      (sin),
  .sclk     (sclk),
  .lat      (lat),
  .gclk     (gclk)
);

`default_nettype wire

//--- sim/led_panel_tb.sv
`default_nettype none

module led_panel_tb
  import led_panel_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LANES       = 4;
  localparam int LINES           = 4;
  localparam int BLANKING_CYCLES = 72;
  localparam int GCLK_PULSES     = 16;
  localparam int CONF_LAT_LEN    = 3;
  localparam int DATA_LAT_LEN    = 1;
  localparam int RESET_CYCLES    = 10;
  localparam int FRAME_CYCLES    = BLANKING_CYCLES + 1 + LINES * NUM_LANES * WORD_BITS;
  localparam int NUM_ROWS        = 5;

  typedef struct packed {
    pixel_t     conf;
    logic [3:0] presses;
    logic [3:0] frames;
  } row_t;

  // conf word, button presses, frames observed
  localparam row_t ROWS [NUM_ROWS] = '{
    '{16'hA5C3, 4'd0, 4'd2},
    '{16'h1234, 4'd1, 4'd1},
    '{16'hFFFF, 4'd2, 4'd2},
    '{16'h5A0F, 4'd3, 4'd1},
    '{16'h8001, 4'd5, 4'd1}
  };

  // Intensity code per colour index
  localparam color_t EXP_COLOR [4] = '{8'h00, 8'h55, 8'hAA, 8'hFF};

  logic                 clock_33 = 1'b0;
  logic                 nrst = 1'b0;
  logic                 color_button = 1'b0;
  pixel_t               conf = '0;
  logic [NUM_LANES-1:0] sin;
  logic                 sclk;
  logic                 lat;
  logic                 gclk;

  pixel_t lane_word [NUM_LANES];
  int     bit_count;
  int     lat_len;
  int     gclk_count;
  int     latch_count;
  int     row_lines;
  logic   sclk_q;
  logic   lat_q;
  logic   gclk_q;
  pixel_t exp_conf;
  color_t exp_color;
  int     cycles = 0;
  int     timeout_limit = 0;
  integer seed = 46;

  led_panel_top i_led_panel_top (
    .clock_33     (clock_33),
    .nrst         (nrst),
    .color_button (color_button),
    .conf         (conf),
    .sin          (sin),
    .sclk         (sclk),
    .lat          (lat),
    .gclk         (gclk)
  );

  always #50 clock_33 = ~clock_33;

  always @(posedge clock_33) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit)
      abort_run("Timeout: the DUT stopped latching lines");
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_word(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp)
      report_mismatch(name, got, exp);
  endtask

  task automatic check_lat_width(input int got, input int exp);
    if (got != exp)
      report_mismatch("lat width", got, exp);
  endtask

  task automatic check_gclk(input int got);
    if (got != GCLK_PULSES)
      report_mismatch("gclk pulses", got, GCLK_PULSES);
  endtask

  // Driver pins quiet in reset and before configuration
  task automatic check_idle();
    if (sin !== '0)
      report_mismatch("sin", 32'(sin), 0);
    if (sclk !== 1'b0)
      report_mismatch("sclk", 32'(sclk), 0);
    if (lat !== 1'b0)
      report_mismatch("lat", 32'(lat), 0);
    if (gclk !== 1'b0)
      report_mismatch("gclk", 32'(gclk), 0);
  endtask

  ////////////////////
  // Bus monitor
  ////////////////////

  task automatic close_latch();
    pixel_t exp_word;
    if (bit_count != WORD_BITS)
      report_mismatch("sclk pulses per latch", bit_count, WORD_BITS);
    if (latch_count == 0) begin
      check_lat_width(lat_len, CONF_LAT_LEN);
      for (int n = 0; n < NUM_LANES; n++)
        check_word($sformatf("sin[%0d]", n), lane_word[n], exp_conf);
    end else begin
      check_lat_width(lat_len, DATA_LAT_LEN);
      for (int n = 0; n < NUM_LANES; n++) begin
        exp_word = {exp_color, 8'((row_lines % LINES) * NUM_LANES + n)};
        check_word($sformatf("sin[%0d]", n), lane_word[n], exp_word);
      end
      // Burst from the previous data latch
      if (row_lines > 0)
        check_gclk(gclk_count);
      row_lines++;
    end
    latch_count++;
    lat_len    = 0;
    bit_count  = 0;
    gclk_count = 0;
  endtask

  always @(negedge clock_33) begin
    if (!nrst) begin
      for (int n = 0; n < NUM_LANES; n++)
        lane_word[n] = '0;
      bit_count   = 0;
      lat_len     = 0;
      gclk_count  = 0;
      latch_count = 0;
      row_lines   = 0;
      sclk_q      = 1'b0;
      lat_q       = 1'b0;
      gclk_q      = 1'b0;
    end else begin
      if (lat)
        lat_len++;
      else if (lat_q)
        close_latch();
      if (sclk && !sclk_q) begin
        for (int n = 0; n < NUM_LANES; n++)
          lane_word[n] = {lane_word[n][WORD_BITS-2:0], sin[n]};
        bit_count++;
      end
      if (gclk && !gclk_q)
        gclk_count++;
      sclk_q = sclk;
      lat_q  = lat;
      gclk_q = gclk;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic apply_reset(input pixel_t conf_word);
    @(posedge clock_33);
    nrst         <= 1'b0;
    conf         <= conf_word;
    color_button <= 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clock_33);
      check_idle();
      @(posedge clock_33);
    end
    nrst <= 1'b1;
    // Controller still in IDLE here
    @(negedge clock_33);
    check_idle();
  endtask

  // All presses land in the first blanking gap
  task automatic press_button(input int count);
    int gap;
    repeat (count) begin
      gap = $unsigned($random(seed)) % 8;
      repeat (gap) @(posedge clock_33);
      @(posedge clock_33);
      color_button <= 1'b1;
      @(posedge clock_33);
      color_button <= 1'b0;
    end
  endtask

  task automatic run_row(input row_t row);
    apply_reset(row.conf);
    exp_conf  = row.conf;
    exp_color = EXP_COLOR[row.presses % 4];
    press_button(row.presses);
    while (row_lines < row.frames * LINES)
      @(posedge clock_33);
  endtask

  initial begin
    for (int r = 0; r < NUM_ROWS; r++)
      timeout_limit += ROWS[r].frames * FRAME_CYCLES + 200;
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(ROWS[r]);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
design/led_panel_pkg.sv
design/frame_source.sv
design/lane_shifter.sv
design/gclk_gen.sv
design/driver_ctrl.sv
design/led_panel_top.sv
sim/led_panel_chk.sv
sim/led_panel_tb.sv

//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = led_panel_tb
FILELIST   = all.f
LOG        = sim.log
FAIL_MSG   = Testbench failed
PASS_MSG   = Testbench passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
